// File: hdl/sched_pkg.sv
package sched_pkg;

  localparam int TAG_W    = 6;
  localparam int CMT_ID_W = 6;
  localparam int DATA_W   = 16;

  typedef logic [TAG_W-1:0]    tag_t;    // Physical register tag
  typedef logic [CMT_ID_W-1:0] cmt_id_t;
  typedef logic [DATA_W-1:0]   data_t;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_AND = 2'd3
  } alu_op_t;

  typedef enum logic [1:0] {
    ST_INIT   = 2'd0,
    ST_WAIT   = 2'd1,
    ST_ISSUED = 2'd2,
    ST_DONE   = 2'd3
  } entry_state_t;

  // ------------------------------
  // Bundles
  // ------------------------------
  typedef struct packed {
    cmt_id_t cmt_id;
    alu_op_t op;
    tag_t    rd_tag;
    tag_t    rs1_tag;
    logic    rs1_ready;
    tag_t    rs2_tag;
    logic    rs2_ready;
    data_t   a;
    data_t   b;
  } disp_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    alu_op_t op;
    tag_t    rd_tag;
    data_t   a;
    data_t   b;
  } issue_t;

  // Result tag broadcast
  typedef struct packed {
    logic valid;
    tag_t tag;
  } wakeup_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    tag_t    rd_tag;
    data_t   result;
  } done_t;

endpackage

// File: hdl/sched_credit_counter.sv
`timescale 1ns/1ps

module sched_credit_counter #(
  parameter int ENTRY_SIZE = 8
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_get_return,
  input  logic [$clog2(ENTRY_SIZE):0]   i_return_val,
  input  logic                          i_put,
  output logic                          o_cre_ret_valid,
  output logic [$clog2(ENTRY_SIZE):0]   o_cre_ret_val
);

  localparam int CNT_W = $clog2(ENTRY_SIZE) + 1;

  logic [CNT_W-1:0] r_occupancy;

  // Puts count every dispatch, flushed ones leave again through the return
  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_occupancy <= '0;
    end else begin
      r_occupancy <= r_occupancy + CNT_W'(i_put) - i_return_val;
    end
  end

  // One credit message per cycle
  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      o_cre_ret_valid <= 1'b0;
      o_cre_ret_val   <= '0;
    end else begin
      o_cre_ret_valid <= i_get_return;
      o_cre_ret_val   <= i_get_return ? i_return_val : '0;
    end
  end

  a_occupancy_max: assert property (
    @(posedge i_clk) disable iff (i_reset_n)
    r_occupancy <= CNT_W'(ENTRY_SIZE)
  ) else $error("occupancy %0d over %0d entries", r_occupancy, ENTRY_SIZE);

endmodule

// File: hdl/sched_age_picker.sv
`timescale 1ns/1ps

module sched_age_picker #(
  parameter int ENTRY_SIZE = 8
) (
  input  logic [ENTRY_SIZE-1:0] i_ready,
  input  logic [ENTRY_SIZE-1:0] i_out_ptr_oh,
  output logic [ENTRY_SIZE-1:0] o_pick_oh
);

  localparam int IDX_W = $clog2(ENTRY_SIZE);

  logic [IDX_W-1:0]        w_ptr_idx;
  logic [2*ENTRY_SIZE-1:0] w_ready_dbl;
  logic [ENTRY_SIZE-1:0]   w_ready_rot;
  logic [ENTRY_SIZE-1:0]   w_pick_rot;
  logic [2*ENTRY_SIZE-1:0] w_pick_dbl;

  // One-hot out pointer to index
  always_comb begin
    w_ptr_idx = '0;
    for (int i = 0; i < ENTRY_SIZE; i++) begin
      if (i_out_ptr_oh[i]) begin
        w_ptr_idx = IDX_W'(i);
      end
    end
  end

  // ------------------------------
  // Rotate, pick lowest, rotate back
  // ------------------------------
  assign w_ready_dbl = {i_ready, i_ready} >> w_ptr_idx;
  assign w_ready_rot = w_ready_dbl[ENTRY_SIZE-1:0];   // Oldest now at bit 0
  assign w_pick_rot  = w_ready_rot & (~w_ready_rot + 1'b1);
  assign w_pick_dbl  = {w_pick_rot, w_pick_rot} << w_ptr_idx;
  assign o_pick_oh   = w_pick_dbl[2*ENTRY_SIZE-1:ENTRY_SIZE];

  // Pick must be a single ready entry, and present whenever any is ready
  always_comb begin
    a_pick_oh: assert (!$isunknown(i_ready) -> ($onehot0(o_pick_oh) &&
                       ((o_pick_oh & ~i_ready) == '0) &&
                       ((i_ready == '0) == (o_pick_oh == '0))))
      else $error("bad pick %b for ready %b", o_pick_oh, i_ready);
  end

endmodule

// File: hdl/sched_entry.sv
`timescale 1ns/1ps

module sched_entry
  import sched_pkg::*;
#(
  parameter int ENTRY_SIZE = 8
) (
  input  logic    i_clk,
  input  logic    i_reset_n,
  input  logic    i_put,
  input  disp_t   i_put_data,
  input  wakeup_t i_wakeup,
  input  logic    i_picked,
  input  logic    i_pipe_done,
  input  logic    i_out_ptr_valid,
  output logic    o_entry_valid,
  output logic    o_entry_ready,
  output issue_t  o_entry,
  output logic    o_done,
  output cmt_id_t o_result_cmt_id,
  output logic    o_finish
);

  entry_state_t r_state;
  disp_t        r_entry;
  logic         r_done_pulse;

  logic w_rs1_hit_put;
  logic w_rs2_hit_put;
  logic w_rs1_hit;
  logic w_rs2_hit;

  // ------------------------------
  // Source wakeup
  // ------------------------------
  assign w_rs1_hit_put = i_wakeup.valid & (i_wakeup.tag == i_put_data.rs1_tag);
  assign w_rs2_hit_put = i_wakeup.valid & (i_wakeup.tag == i_put_data.rs2_tag);
  assign w_rs1_hit     = i_wakeup.valid & (i_wakeup.tag == r_entry.rs1_tag);
  assign w_rs2_hit     = i_wakeup.valid & (i_wakeup.tag == r_entry.rs2_tag);

  always_ff @(posedge i_clk) begin
    if (i_put) begin
      r_entry           <= i_put_data;
      r_entry.rs1_ready <= i_put_data.rs1_ready | w_rs1_hit_put;  // Same-cycle match
      r_entry.rs2_ready <= i_put_data.rs2_ready | w_rs2_hit_put;
    end else begin
      if (w_rs1_hit) begin
        r_entry.rs1_ready <= 1'b1;
      end
      if (w_rs2_hit) begin
        r_entry.rs2_ready <= 1'b1;
      end
    end
  end

  // ------------------------------
  // State machine
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_state      <= ST_INIT;
      r_done_pulse <= 1'b0;
    end else begin
      r_done_pulse <= 1'b0;
      case (r_state)
        ST_INIT: begin
          if (i_put) begin
            r_state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (i_picked) begin
            r_state <= ST_ISSUED;
          end
        end
        ST_ISSUED: begin
          if (i_pipe_done) begin
            r_state      <= ST_DONE;
            r_done_pulse <= 1'b1;
          end
        end
        ST_DONE: begin
          if (i_out_ptr_valid) begin
            r_state <= ST_INIT;   // Retired in order
          end
        end
        default: r_state <= ST_INIT;
      endcase
    end
  end

  assign o_entry_valid = (r_state != ST_INIT);
  assign o_entry_ready = (r_state == ST_WAIT) & r_entry.rs1_ready & r_entry.rs2_ready;

  assign o_entry.valid  = o_entry_valid;
  assign o_entry.cmt_id = r_entry.cmt_id;
  assign o_entry.op     = r_entry.op;
  assign o_entry.rd_tag = r_entry.rd_tag;
  assign o_entry.a      = r_entry.a;
  assign o_entry.b      = r_entry.b;

  assign o_done          = r_done_pulse;
  assign o_result_cmt_id = r_entry.cmt_id;
  assign o_finish        = (r_state == ST_DONE) & i_out_ptr_valid;

endmodule

// File: hdl/scheduler.sv
`timescale 1ns/1ps

module scheduler
  import sched_pkg::*;
#(
  parameter int ENTRY_SIZE = 8
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_disp_valid,
  input  disp_t                       i_disp,
  input  logic                        i_flush,
  input  logic                        i_stall,
  input  wakeup_t                     i_wakeup,
  input  logic                        i_pipe_done,
  input  logic [ENTRY_SIZE-1:0]       i_pipe_index_oh,
  input  data_t                       i_pipe_result,
  output issue_t                      o_issue,
  output logic [ENTRY_SIZE-1:0]       o_iss_index_oh,
  output done_t                       o_done_report,
  output logic                        o_cre_ret_valid,
  output logic [$clog2(ENTRY_SIZE):0] o_cre_ret_val
);

  localparam int CNT_W = $clog2(ENTRY_SIZE) + 1;

  logic [ENTRY_SIZE-1:0] r_in_ptr_oh;
  logic [ENTRY_SIZE-1:0] r_out_ptr_oh;
  logic [ENTRY_SIZE-1:0] w_entry_valid;
  logic [ENTRY_SIZE-1:0] w_entry_ready;
  logic [ENTRY_SIZE-1:0] w_entry_done;
  logic [ENTRY_SIZE-1:0] w_entry_finish;
  logic [ENTRY_SIZE-1:0] w_pick_oh;
  issue_t                w_entry [ENTRY_SIZE];
  cmt_id_t               w_entry_cmt_id [ENTRY_SIZE];
  data_t                 r_result [ENTRY_SIZE];

  logic             w_accept;
  logic             w_flush_drop;
  logic             w_finish_any;
  logic [CNT_W-1:0] w_return_val;

  assign w_accept     = i_disp_valid & ~i_flush;
  assign w_flush_drop = i_disp_valid & i_flush;
  assign w_finish_any = |w_entry_finish;

  // ------------------------------
  // In / out pointers
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset_n) begin
      r_in_ptr_oh  <= ENTRY_SIZE'(1);
      r_out_ptr_oh <= ENTRY_SIZE'(1);
    end else begin
      if (w_accept) begin
        r_in_ptr_oh <= {r_in_ptr_oh[ENTRY_SIZE-2:0], r_in_ptr_oh[ENTRY_SIZE-1]};
      end
      if (w_finish_any) begin
        r_out_ptr_oh <= {r_out_ptr_oh[ENTRY_SIZE-2:0], r_out_ptr_oh[ENTRY_SIZE-1]};
      end
    end
  end

  // Freed entry plus any dropped dispatch
  assign w_return_val = CNT_W'(w_finish_any) + CNT_W'(w_flush_drop);

  sched_credit_counter #(.ENTRY_SIZE(ENTRY_SIZE)) u_credit (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_get_return   (w_finish_any | w_flush_drop),
    .i_return_val   (w_return_val),
    .i_put          (i_disp_valid),
    .o_cre_ret_valid(o_cre_ret_valid),
    .o_cre_ret_val  (o_cre_ret_val)
  );

  sched_age_picker #(.ENTRY_SIZE(ENTRY_SIZE)) u_picker (
    .i_ready     (w_entry_valid & w_entry_ready & {ENTRY_SIZE{~i_stall}}),
    .i_out_ptr_oh(r_out_ptr_oh),
    .o_pick_oh   (w_pick_oh)
  );

  for (genvar i = 0; i < ENTRY_SIZE; i++) begin : g_entry
    sched_entry #(.ENTRY_SIZE(ENTRY_SIZE)) u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_put          (w_accept & r_in_ptr_oh[i]),
      .i_put_data     (i_disp),
      .i_wakeup       (i_wakeup),
      .i_picked       (w_pick_oh[i]),
      .i_pipe_done    (i_pipe_done & i_pipe_index_oh[i]),
      .i_out_ptr_valid(r_out_ptr_oh[i]),
      .o_entry_valid  (w_entry_valid[i]),
      .o_entry_ready  (w_entry_ready[i]),
      .o_entry        (w_entry[i]),
      .o_done         (w_entry_done[i]),
      .o_result_cmt_id(w_entry_cmt_id[i]),
      .o_finish       (w_entry_finish[i])
    );

    always_ff @(posedge i_clk) begin
      if (i_pipe_done && i_pipe_index_oh[i]) begin
        r_result[i] <= i_pipe_result;
      end
    end
  end

  // ------------------------------
  // Issue and done report muxes
  // ------------------------------
  always_comb begin
    o_issue       = '0;
    o_done_report = '0;
    for (int i = 0; i < ENTRY_SIZE; i++) begin
      if (w_pick_oh[i]) begin
        o_issue = issue_t'(o_issue | w_entry[i]);
      end
      if (w_entry_done[i]) begin
        o_done_report.cmt_id = o_done_report.cmt_id | w_entry_cmt_id[i];
        o_done_report.rd_tag = o_done_report.rd_tag | w_entry[i].rd_tag;
        o_done_report.result = o_done_report.result | r_result[i];
      end
    end
    o_done_report.valid = |w_entry_done;
  end

  assign o_iss_index_oh = w_pick_oh;

  a_disp_free_entry: assert property (
    @(posedge i_clk) disable iff (i_reset_n)
    w_accept |-> ((r_in_ptr_oh & w_entry_valid) == '0)
  ) else $error("dispatch into occupied entry, in_ptr %b", r_in_ptr_oh);

endmodule

// File: hdl/alu_exec_pipe.sv
`timescale 1ns/1ps

module alu_exec_pipe
  import sched_pkg::*;
#(
  parameter int ENTRY_SIZE = 8
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  issue_t                i_issue,
  input  logic [ENTRY_SIZE-1:0] i_index_oh,
  output wakeup_t               o_wakeup,
  output logic                  o_done,
  output logic [ENTRY_SIZE-1:0] o_done_index_oh,
  output data_t                 o_result
);

  issue_t                r_s1;
  logic [ENTRY_SIZE-1:0] r_s1_index_oh;
  logic                  r_s2_valid;
  tag_t                  r_s2_tag;
  logic [ENTRY_SIZE-1:0] r_s2_index_oh;
  data_t                 r_s2_result;

  function automatic data_t alu_calc(alu_op_t op, data_t a, data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      default: return a & b;
    endcase
  endfunction

  // Stage 1 captures the issued op
  always_ff @(posedge i_clk) begin
    r_s1          <= i_issue;
    r_s1_index_oh <= i_index_oh;
    if (i_reset_n) begin
      r_s1.valid <= 1'b0;
    end
  end

  // Stage 2 holds the result
  always_ff @(posedge i_clk) begin
    r_s2_valid    <= r_s1.valid;
    r_s2_tag      <= r_s1.rd_tag;
    r_s2_index_oh <= r_s1_index_oh;
    r_s2_result   <= alu_calc(r_s1.op, r_s1.a, r_s1.b);
    if (i_reset_n) begin
      r_s2_valid <= 1'b0;
    end
  end

  assign o_wakeup.valid  = r_s2_valid;
  assign o_wakeup.tag    = r_s2_tag;
  assign o_done          = r_s2_valid;
  assign o_done_index_oh = r_s2_index_oh;
  assign o_result        = r_s2_result;

endmodule

// File: hdl/sched_top.sv
`timescale 1ns/1ps

module sched_top
  import sched_pkg::*;
#(
  parameter int ENTRY_SIZE = 8
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_disp_valid,
  input  disp_t                       i_disp,
  input  logic                        i_flush,
  input  logic                        i_stall,
  output done_t                       o_done_report,
  output logic                        o_cre_ret_valid,
  output logic [$clog2(ENTRY_SIZE):0] o_cre_ret_val
);

  issue_t                w_issue;
  logic [ENTRY_SIZE-1:0] w_iss_index_oh;
  wakeup_t               w_wakeup;
  logic                  w_pipe_done;
  logic [ENTRY_SIZE-1:0] w_pipe_index_oh;
  data_t                 w_pipe_result;

  scheduler #(.ENTRY_SIZE(ENTRY_SIZE)) u_scheduler (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp         (i_disp),
    .i_flush        (i_flush),
    .i_stall        (i_stall),
    .i_wakeup       (w_wakeup),
    .i_pipe_done    (w_pipe_done),
    .i_pipe_index_oh(w_pipe_index_oh),
    .i_pipe_result  (w_pipe_result),
    .o_issue        (w_issue),
    .o_iss_index_oh (w_iss_index_oh),
    .o_done_report  (o_done_report),
    .o_cre_ret_valid(o_cre_ret_valid),
    .o_cre_ret_val  (o_cre_ret_val)
  );

  alu_exec_pipe #(.ENTRY_SIZE(ENTRY_SIZE)) u_alu (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_issue        (w_issue),
    .i_index_oh     (w_iss_index_oh),
    .o_wakeup       (w_wakeup),
    .o_done         (w_pipe_done),
    .o_done_index_oh(w_pipe_index_oh),
    .o_result       (w_pipe_result)
  );

endmodule

// File: sim/tb_sched_top.sv
`timescale 1ns/1ps

module tb_sched_top
  import sched_pkg::*;
#(
  parameter int ENTRY_SIZE = 8,
  parameter int NUM_OPS    = 300
) ();

  localparam int CNT_W          = $clog2(ENTRY_SIZE) + 1;
  localparam int NUM_DIRECTED   = 4;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 200;
  localparam int ID_SPAN        = 32;   // Accepted ops below, flushed ops above

  logic             clk;
  logic             reset_n;
  logic             disp_valid;
  disp_t            disp;
  logic             flush;
  logic             stall;
  done_t            done_report;
  logic             cre_ret_valid;
  logic [CNT_W-1:0] cre_ret_val;

  logic [31:0] lfsr_state;
  int          cycle;

  // Scoreboard, indexed by commit id
  data_t exp_result  [64];
  tag_t  exp_tag     [64];
  bit    outstanding [64];
  bit    done_seen   [64];
  bit    lat_check   [64];
  int    dep1        [64];
  int    dep2        [64];
  int    disp_cycle  [64];

  int credits;
  int next_id;
  int flush_count;
  int open_ops;
  int accepted;
  int sent_total;
  int returned_total;
  int stall_reports;
  int stall_left;
  int error_count;

  sched_top #(.ENTRY_SIZE(ENTRY_SIZE)) DUT (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_disp_valid   (disp_valid),
    .i_disp         (disp),
    .i_flush        (flush),
    .i_stall        (stall),
    .o_done_report  (done_report),
    .o_cre_ret_valid(cre_ret_valid),
    .o_cre_ret_val  (cre_ret_val)
  );

  always #5 clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v          = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic data_t ref_alu(input alu_op_t op, input data_t a, input data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      default: return a & b;
    endcase
  endfunction

  task automatic fail_now(input string why);
    error_count++;
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "stopping at first error");
  endtask

  task automatic value_mismatch(input string name, input longint got, input longint exp);
    fail_now($sformatf("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Wait on a recent open producer, or take the source as ready
  task automatic pick_source(input bit all_ready, output tag_t tag, output logic ready,
                             output int dep);
    int cand [$];
    int p;
    for (int back = 1; back <= ENTRY_SIZE; back++) begin
      p = (next_id - back + ID_SPAN) % ID_SPAN;
      if (outstanding[p] && !(done_report.valid && done_report.cmt_id == p)) begin
        cand.push_back(p);   // Not yet reported, so its wakeup is not past
      end
    end
    if (!all_ready && cand.size() != 0 && rand_bits(2) != 0) begin
      dep   = cand[rand_bits(3) % cand.size()];
      tag   = tag_t'(dep);
      ready = 1'b0;
    end else begin
      dep   = -1;
      tag   = tag_t'(rand_bits(6));
      ready = 1'b1;
    end
  endtask

  task automatic send_op(input bit drop, input bit all_ready);
    disp_t d;
    int    id;
    d.op = alu_op_t'(rand_bits(2));
    d.a  = data_t'(rand_bits(16));
    d.b  = data_t'(rand_bits(16));
    if (drop) begin
      id          = ID_SPAN + flush_count % ID_SPAN;
      flush_count++;
      d.rs1_tag   = '0;
      d.rs1_ready = 1'b1;
      d.rs2_tag   = '0;
      d.rs2_ready = 1'b1;
    end else begin
      id = next_id;
      pick_source(all_ready, d.rs1_tag, d.rs1_ready, dep1[id]);
      pick_source(all_ready, d.rs2_tag, d.rs2_ready, dep2[id]);
      exp_result[id]  = ref_alu(d.op, d.a, d.b);
      exp_tag[id]     = tag_t'(id);
      outstanding[id] = 1'b1;
      done_seen[id]   = 1'b0;
      lat_check[id]   = all_ready;
      disp_cycle[id]  = cycle;
      open_ops++;
      accepted++;
      next_id = (next_id + 1) % ID_SPAN;
    end
    d.cmt_id = cmt_id_t'(id);
    d.rd_tag = tag_t'(id);
    credits--;
    sent_total++;
    disp       = d;
    disp_valid = 1'b1;
    flush      = drop;
  endtask

  task automatic wait_drained();
    while (open_ops != 0 || credits != ENTRY_SIZE) begin
      next_cycle();
    end
  endtask

  // ------------------------------
  // Checker
  // ------------------------------
  task automatic check_report(input done_t r);
    int id;
    id = int'(r.cmt_id);
    assert (id < ID_SPAN)
      else fail_now($sformatf("Flushed dispatch with commit id %0d was reported", id));
    assert (outstanding[id])
      else fail_now($sformatf("Done report for commit id %0d with no open operation", id));
    assert (r.rd_tag == exp_tag[id])
      else value_mismatch("o_done_report.rd_tag", r.rd_tag, exp_tag[id]);
    assert (r.result == exp_result[id])
      else value_mismatch("o_done_report.result", r.result, exp_result[id]);
    assert (dep1[id] < 0 || done_seen[dep1[id]])
      else fail_now($sformatf("Commit id %0d reported before producer %0d", id, dep1[id]));
    assert (dep2[id] < 0 || done_seen[dep2[id]])
      else fail_now($sformatf("Commit id %0d reported before producer %0d", id, dep2[id]));
    if (lat_check[id]) begin
      assert (cycle - disp_cycle[id] == 4)
        else value_mismatch("done report latency", cycle - disp_cycle[id], 4);
    end
    outstanding[id] = 1'b0;
    done_seen[id]   = 1'b1;
    open_ops--;
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > TIMEOUT_CYCLES) begin
      fail_now($sformatf("Timeout after %0d cycles, %0d operations never reported",
                         cycle, open_ops));
    end
  end

  always @(negedge clk) begin
    if (!reset_n) begin
      if (cre_ret_valid) begin
        credits        += int'(cre_ret_val);
        returned_total += int'(cre_ret_val);
        assert (credits <= ENTRY_SIZE)
          else fail_now("More credits returned than were dispatched");
      end
      if (stall) begin
        if (done_report.valid) begin
          stall_reports++;
        end
        assert (stall_reports <= 3)
          else fail_now("Done reports kept coming while the issue was stalled");
      end else begin
        stall_reports = 0;
      end
      if (done_report.valid) begin
        check_report(done_report);
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    clk            = 1'b0;
    reset_n        = 1'b1;
    disp_valid     = 1'b0;
    disp           = '0;
    flush          = 1'b0;
    stall          = 1'b0;
    lfsr_state     = 32'd70060;
    cycle          = 0;
    credits        = ENTRY_SIZE;
    next_id        = 0;
    flush_count    = 0;
    open_ops       = 0;
    accepted       = 0;
    sent_total     = 0;
    returned_total = 0;
    stall_reports  = 0;
    stall_left     = 0;
    error_count    = 0;
    for (int i = 0; i < 64; i++) begin
      outstanding[i] = 1'b0;
      done_seen[i]   = 1'b0;
      lat_check[i]   = 1'b0;
      dep1[i]        = -1;
      dep2[i]        = -1;
    end

    repeat (4) @(posedge clk);
    #1;
    reset_n = 1'b0;
    next_cycle();

    // Single ready ops into an empty queue
    for (int n = 0; n < NUM_DIRECTED; n++) begin
      send_op(1'b0, 1'b1);
      next_cycle();
      disp_valid = 1'b0;
      wait_drained();
    end

    while (accepted < NUM_OPS) begin
      if (stall_left == 0 && rand_bits(4) == 0) begin
        stall_left = 4 + rand_bits(3);
      end
      stall = (stall_left != 0);
      if (stall_left != 0) begin
        stall_left--;
      end
      disp_valid = 1'b0;
      flush      = 1'b0;
      if (credits > 0 && rand_bits(2) != 0) begin
        send_op(rand_bits(3) == 0, 1'b0);
      end
      next_cycle();
    end
    disp_valid = 1'b0;
    flush      = 1'b0;
    stall      = 1'b0;

    while (open_ops != 0) begin
      next_cycle();
    end
    repeat (ENTRY_SIZE + 2) next_cycle();   // Freed entries return their credits
    assert (credits == ENTRY_SIZE) else value_mismatch("credits held", credits, ENTRY_SIZE);
    assert (returned_total == sent_total)
      else value_mismatch("o_cre_ret_val total", returned_total, sent_total);

    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: list.f
hdl/sched_pkg.sv
hdl/sched_credit_counter.sv
hdl/sched_age_picker.sv
hdl/sched_entry.sv
hdl/scheduler.sv
hdl/alu_exec_pipe.sv
hdl/sched_top.sv
sim/tb_sched_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_sched_top -Mdir "$OBJ" -o tb_sched_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_sched_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
